// ==== fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// prefetch front end sizing
////////////////////////////////////////////////////////////////////////////

// entries the prefetcher may reserve in the fetch fifo
// the fifo itself holds one more entry than this
`define FETCH_NUM_REQS 2

// byte address width of the fetch bus and of every pc
`define FETCH_ADDR_W 32

// width of one fetch bus beat, a full doubleword
// the aligner assumes four halfwords per beat
`define FETCH_DATA_W 64

`endif

// ==== fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

  //////////////////////////////////////////////////////////////////////////
  // memory side
  //////////////////////////////////////////////////////////////////////////

  // one beat returned by memory while ack is high
  typedef struct packed {
    logic [`FETCH_DATA_W-1:0] rdata;
    // bus or access fault on this doubleword
    logic                     err;
  } mem_rsp_t;

  // phases of the four-phase req/ack handshake
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_REQ,
    BUS_RELEASE
  } bus_state_e;

  //////////////////////////////////////////////////////////////////////////
  // decode side
  //////////////////////////////////////////////////////////////////////////

  // one aligned instruction toward decode
  // for a compressed one the upper half holds the next halfword
  typedef struct packed {
    logic [31:0]              insn;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic                     is_comp;
    logic                     err;
  } ir_reg_t;

endpackage

// ==== fetch_fifo64.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_fifo64 (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // flush and restart pc
  input  logic                       clear_i,
  input  logic [`FETCH_ADDR_W-1:0]   clear_addr_i,
  // upper entries occupancy toward the request controller
  output logic [`FETCH_NUM_REQS-1:0] busy_o,
  // response push
  input  logic                       in_valid_i,
  input  fetch_pkg::mem_rsp_t        in_rsp_i,
  // decode port
  output logic [1:0]                 out_valid_o,
  input  logic [1:0]                 out_ready_i,
  output fetch_pkg::ir_reg_t         out_instr0_o,
  output fetch_pkg::ir_reg_t         out_instr1_o
);
  import fetch_pkg::*;

  localparam int unsigned DEPTH = `FETCH_NUM_REQS + 1;
  localparam int unsigned PC_W  = `FETCH_ADDR_W - 1;
  localparam int unsigned DW    = `FETCH_DATA_W;

  // fifo storage, entry 0 is the head
  mem_rsp_t [DEPTH-1:0] entry_d;
  mem_rsp_t [DEPTH-1:0] entry_q;
  logic     [DEPTH-1:0] valid_d;
  logic     [DEPTH-1:0] valid_q;
  logic     [DEPTH-1:0] lowest_free;
  logic     [DEPTH-1:0] valid_pushed;
  logic     [DEPTH-1:0] valid_popped;
  logic     [DEPTH-1:0] entry_en;
  logic                 pop;

  // aligner window
  logic [2*DW-1:0] win;
  logic [5:0]      comp_flag;
  logic            one_word;
  logic            two_words;
  logic            any_word;
  logic [3:0]      avail_hw;
  logic            err_w0;
  logic            err_w1;

  // instruction slicing, all positions in halfwords
  logic [1:0] sel;
  logic       comp0;
  logic       comp1;
  logic [2:0] len0;
  logic [2:0] len1;
  logic [2:0] end0;
  logic [2:0] end1;
  logic       fit0;
  logic       fit1;
  logic       bad0;
  logic       bad1;

  // transfer bookkeeping
  logic [1:0] xfr;
  logic [2:0] hw_end;
  logic [2:0] incr;

  // halfword pc and its two look-ahead copies
  logic [PC_W-1:0] pc_q;
  logic [PC_W-1:0] pc2_q;
  logic [PC_W-1:0] pc4_q;
  logic [PC_W-1:0] pc_next;
  logic [PC_W-1:0] pc_d;
  logic            pc_en;

  ////////////////////////////////////////////////////////////////////////////
  // window build
  ////////////////////////////////////////////////////////////////////////////

  // head doubleword comes from entry 0, or straight from the bus when empty
  assign win[DW-1:0]    = valid_q[0] ? entry_q[0].rdata : in_rsp_i.rdata;
  // second doubleword from entry 1, or the incoming beat behind entry 0
  assign win[2*DW-1:DW] = valid_q[1] ? entry_q[1].rdata : in_rsp_i.rdata;

  assign err_w0 = valid_q[0] ? entry_q[0].err : in_rsp_i.err;
  assign err_w1 = valid_q[1] ? entry_q[1].err : in_rsp_i.err;

  // how much of the window holds real data this cycle
  assign one_word  = (valid_q[0] & ~valid_q[1] & ~in_valid_i) |
                     (~valid_q[0] & in_valid_i);
  assign two_words = valid_q[1] | (valid_q[0] & in_valid_i);
  assign any_word  = one_word | two_words;
  assign avail_hw  = two_words ? 4'd8 : (one_word ? 4'd4 : 4'd0);

  // rvc rule: low two bits other than 11 mean a 16-bit encoding
  // an instr1 never starts past halfword 5
  for (genvar i = 0; i < 6; i++) begin : g_comp
    assign comp_flag[i] = (win[i*16 +: 2] != 2'b11);
  end

  ////////////////////////////////////////////////////////////////////////////
  // aligner
  ////////////////////////////////////////////////////////////////////////////

  assign sel = pc_q[1:0];

  // instr0 starts at sel, instr1 right after it
  assign comp0 = comp_flag[sel];
  assign len0  = comp0 ? 3'd1 : 3'd2;
  assign end0  = {1'b0, sel} + len0;
  assign comp1 = comp_flag[end0];
  assign len1  = comp1 ? 3'd1 : 3'd2;
  assign end1  = end0 + len1;

  // complete when the last halfword lies inside the valid part
  assign fit0 = ({1'b0, end0} <= avail_hw);
  assign fit1 = ({1'b0, end1} <= avail_hw);

  // faulty head word: instr0 goes out alone so the trap is precise
  // faulty second word only hits an instruction reaching past halfword 3
  assign bad0 = err_w0 | (two_words & err_w1 & (end0 > 3'd4));
  assign bad1 = two_words & err_w1 & (end1 > 3'd4);

  // nothing past the first faulty instruction is presented
  assign out_valid_o[0] = any_word & (fit0 | bad0);
  assign out_valid_o[1] = any_word & fit1 & ~bad0;

  assign out_instr0_o.insn    = win[{sel, 4'b0000} +: 32];
  assign out_instr0_o.pc      = {pc_q, 1'b0};
  assign out_instr0_o.is_comp = comp0;
  assign out_instr0_o.err     = bad0;

  assign out_instr1_o.insn    = win[{end0, 4'b0000} +: 32];
  assign out_instr1_o.pc      = {(comp0 ? pc2_q : pc4_q), 1'b0};
  assign out_instr1_o.is_comp = comp1;
  assign out_instr1_o.err     = bad1;

  ////////////////////////////////////////////////////////////////////////////
  // consume and pc update
  ////////////////////////////////////////////////////////////////////////////

  // decode takes instr1 only together with instr0
  assign xfr = out_valid_o & out_ready_i;

  // halfword position just past the last consumed instruction
  assign hw_end = xfr[1] ? end1 : end0;
  assign incr   = xfr[0] ? (hw_end - {1'b0, sel}) : 3'd0;

  // head doubleword is done once consumption reaches its end
  assign pop = xfr[0] & (hw_end >= 3'd4);

  assign pc_next = pc_q + PC_W'(incr);
  assign pc_d    = clear_i ? clear_addr_i[`FETCH_ADDR_W-1:1] : pc_next;
  assign pc_en   = clear_i | xfr[0];

  // pc+2 and pc+4 kept in flops, so instr1's pc is only a mux
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q  <= '0;
      pc2_q <= PC_W'(1);
      pc4_q <= PC_W'(2);
    end else if (pc_en) begin
      pc_q  <= pc_d;
      pc2_q <= pc_d + PC_W'(1);
      pc4_q <= pc_d + PC_W'(2);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fifo control
  ////////////////////////////////////////////////////////////////////////////

  // top entries tell the controller whether another beat fits
  assign busy_o = valid_q[DEPTH-1 -: `FETCH_NUM_REQS];

  for (genvar i = 0; i < DEPTH; i++) begin : g_entry
    // write pointer, first empty slot above a full one
    if (i == 0) begin : g_bottom
      assign lowest_free[i] = ~valid_q[i];
    end else begin : g_upper
      assign lowest_free[i] = ~valid_q[i] & valid_q[i-1];
    end

    assign valid_pushed[i] = valid_q[i] | (in_valid_i & lowest_free[i]);

    if (i < DEPTH - 1) begin : g_shift
      // a pop moves everything one slot down
      assign valid_popped[i] = pop ? valid_pushed[i+1] : valid_pushed[i];
      // load on shift-in, or on a push into this slot without a pop
      assign entry_en[i] = (pop & valid_pushed[i+1]) |
                           (~pop & in_valid_i & lowest_free[i]);
      assign entry_d[i]  = valid_q[i+1] ? entry_q[i+1] : in_rsp_i;
    end else begin : g_top
      // nothing above the top slot to shift in
      assign valid_popped[i] = ~pop & valid_pushed[i];
      assign entry_en[i]     = in_valid_i & lowest_free[i];
      assign entry_d[i]      = in_rsp_i;
    end

    // clear drops stored entries and any beat arriving with it
    assign valid_d[i] = valid_popped[i] & ~clear_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // payload flops
  for (genvar i = 0; i < DEPTH; i++) begin : g_store
    always_ff @(posedge clk_i) begin
      if (entry_en[i]) begin
        entry_q[i] <= entry_d[i];
      end
    end
  end

endmodule

// ==== prefetch_ctrl.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module prefetch_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // redirect, halfword aligned target
  input  logic                       redirect_i,
  input  logic [`FETCH_ADDR_W-1:0]   redirect_addr_i,
  // fifo fill state, top bit means no room
  input  logic [`FETCH_NUM_REQS-1:0] fifo_busy_i,
  // four-phase memory port
  output logic                       mem_req_o,
  output logic [`FETCH_ADDR_W-1:0]   mem_addr_o,
  input  logic                       mem_ack_i,
  input  fetch_pkg::mem_rsp_t        mem_rsp_i,
  // response toward the fifo
  output logic                       rsp_valid_o,
  output fetch_pkg::mem_rsp_t        rsp_o
);
  import fetch_pkg::*;

  // bits above the doubleword offset
  localparam int unsigned DA_W = `FETCH_ADDR_W - 3;

  bus_state_e      state_q;
  bus_state_e      state_d;
  logic            stale_q;
  logic            stale_d;
  logic [DA_W-1:0] fetch_addr_q;
  logic [DA_W-1:0] fetch_addr_d;
  logic [DA_W-1:0] req_addr_q;
  logic            can_req;
  logic            launch;
  logic            ack_seen;

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  // ack must be low before req may rise again
  // a redirect empties the fifo, so room is guaranteed then
  assign can_req = ~mem_ack_i & (redirect_i | ~fifo_busy_i[`FETCH_NUM_REQS-1]);

  always_comb begin
    state_d = state_q;
    launch  = 1'b0;
    unique case (state_q)
      BUS_IDLE: begin
        if (can_req) begin
          state_d = BUS_REQ;
          launch  = 1'b1;
        end
      end
      BUS_REQ: begin
        // req drops on the edge after ack is seen
        if (mem_ack_i) begin
          state_d = BUS_RELEASE;
        end
      end
      BUS_RELEASE: begin
        // wait for ack low, then go straight on if there is room
        if (can_req) begin
          state_d = BUS_REQ;
          launch  = 1'b1;
        end else if (!mem_ack_i) begin
          state_d = BUS_IDLE;
        end
      end
      default: begin
        state_d = BUS_IDLE;
      end
    endcase
  end

  assign ack_seen = (state_q == BUS_REQ) & mem_ack_i;

  // a redirect in flight makes the pending beat stale
  // a fresh launch always uses the current address, so it clears the flag
  always_comb begin
    stale_d = stale_q;
    if (launch) begin
      stale_d = 1'b0;
    end else if (redirect_i && (state_q != BUS_IDLE)) begin
      stale_d = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response forwarding and address
  ////////////////////////////////////////////////////////////////////////////

  // single-cycle pulse in the first ack cycle
  // a beat meeting a redirect in the same cycle is stale too
  assign rsp_valid_o = ack_seen & ~stale_q & ~redirect_i;
  assign rsp_o       = mem_rsp_i;

  // next doubleword to fetch
  assign fetch_addr_d = redirect_i  ? redirect_addr_i[`FETCH_ADDR_W-1:3] :
                        rsp_valid_o ? fetch_addr_q + DA_W'(1) :
                                      fetch_addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= BUS_IDLE;
      stale_q      <= 1'b0;
      fetch_addr_q <= '0;
    end else begin
      state_q      <= state_d;
      stale_q      <= stale_d;
      fetch_addr_q <= fetch_addr_d;
    end
  end

  // bus address captured at launch, held while req is high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_addr_q <= '0;
    end else if (launch) begin
      req_addr_q <= fetch_addr_d;
    end
  end

  assign mem_req_o  = (state_q == BUS_REQ);
  assign mem_addr_o = {req_addr_q, 3'b000};

endmodule

// ==== prefetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module prefetch_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // redirect from execute
  input  logic                     redirect_i,
  input  logic [`FETCH_ADDR_W-1:0] redirect_addr_i,
  // memory port
  output logic                     mem_req_o,
  output logic [`FETCH_ADDR_W-1:0] mem_addr_o,
  input  logic                     mem_ack_i,
  input  fetch_pkg::mem_rsp_t      mem_rsp_i,
  // decode port
  output logic [1:0]               out_valid_o,
  input  logic [1:0]               out_ready_i,
  output fetch_pkg::ir_reg_t       out_instr0_o,
  output fetch_pkg::ir_reg_t       out_instr1_o
);
  import fetch_pkg::*;

  logic [`FETCH_NUM_REQS-1:0] fifo_busy;
  logic                       rsp_valid;
  mem_rsp_t                   rsp;

  // bus requests and stale beat filtering
  prefetch_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .redirect_i      (redirect_i),
    .redirect_addr_i (redirect_addr_i),
    .fifo_busy_i     (fifo_busy),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rsp_i       (mem_rsp_i),
    .rsp_valid_o     (rsp_valid),
    .rsp_o           (rsp)
  );

  // buffering and alignment, restarted at the redirect pc
  fetch_fifo64 u_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (redirect_i),
    .clear_addr_i (redirect_addr_i),
    .busy_o       (fifo_busy),
    .in_valid_i   (rsp_valid),
    .in_rsp_i     (rsp),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_instr0_o (out_instr0_o),
    .out_instr1_o (out_instr1_o)
  );

endmodule

// ==== tb_mem_responder.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module tb_mem_responder (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // memory contents, 64 doublewords that repeat every 512 bytes
  input  logic [`FETCH_DATA_W-1:0] image_i [64],
  // four-phase port, seen from the memory side
  input  logic                     req_i,
  input  logic [`FETCH_ADDR_W-1:0] addr_i,
  output logic                     ack_o,
  output fetch_pkg::mem_rsp_t      rsp_o,
  // extra wait cycles before each ack edge, 0 to 3
  input  logic [1:0]               delay_i,
  // doubleword that answers with a fault
  input  logic                     err_en_i,
  input  logic [5:0]               err_idx_i
);

  logic [1:0] wait_cnt;
  logic [5:0] idx;

  assign idx = addr_i[8:3];

  // falling edge, so ack and data are settled at the DUT's rising edge
  always_ff @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o    <= 1'b0;
      wait_cnt <= 2'd0;
      rsp_o    <= '0;
    end else if (ack_o) begin
      // return phase, ack follows req down after its own delay
      if (!req_i) begin
        if (wait_cnt >= delay_i) begin
          ack_o    <= 1'b0;
          wait_cnt <= 2'd0;
        end else begin
          wait_cnt <= wait_cnt + 2'd1;
        end
      end
    end else if (req_i) begin
      if (wait_cnt >= delay_i) begin
        ack_o       <= 1'b1;
        rsp_o.rdata <= image_i[idx];
        rsp_o.err   <= err_en_i && (idx == err_idx_i);
        wait_cnt    <= 2'd0;
      end else begin
        wait_cnt <= wait_cnt + 2'd1;
      end
    end
  end

endmodule

// ==== tb_prefetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module tb_prefetch_top;
  import fetch_pkg::*;

  localparam int WAIT_LIMIT = 2000;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     redirect;
  logic [`FETCH_ADDR_W-1:0] redirect_addr;
  logic                     mem_req;
  logic [`FETCH_ADDR_W-1:0] mem_addr;
  logic                     mem_ack;
  mem_rsp_t                 mem_rsp;
  logic [1:0]               out_valid;
  logic [1:0]               out_ready;
  ir_reg_t                  instr0;
  ir_reg_t                  instr1;
  logic [1:0]               ack_delay;
  logic                     err_en;
  logic [5:0]               err_idx;

  // stimulus and model state
  logic [31:0]              rnd_state;
  logic [`FETCH_DATA_W-1:0] image [64];
  logic [31:0]              model_pc;
  logic                     model_err_on;
  logic                     err_arm;
  logic                     skipping;
  logic                     err_seen;
  logic                     req_prev;
  logic [`FETCH_ADDR_W-1:0] addr_prev;
  int                       xfer_count;
  int                       checks;
  int                       errors;

  prefetch_top u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .redirect_i      (redirect),
    .redirect_addr_i (redirect_addr),
    .mem_req_o       (mem_req),
    .mem_addr_o      (mem_addr),
    .mem_ack_i       (mem_ack),
    .mem_rsp_i       (mem_rsp),
    .out_valid_o     (out_valid),
    .out_ready_i     (out_ready),
    .out_instr0_o    (instr0),
    .out_instr1_o    (instr1)
  );

  tb_mem_responder u_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .image_i   (image),
    .req_i     (mem_req),
    .addr_i    (mem_addr),
    .ack_o     (mem_ack),
    .rsp_o     (mem_rsp),
    .delay_i   (ack_delay),
    .err_en_i  (err_en),
    .err_idx_i (err_idx)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // random numbers and image
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    rnd_state = rnd_state ^ (rnd_state << 13);
    rnd_state = rnd_state ^ (rnd_state >> 17);
    rnd_state = rnd_state ^ (rnd_state << 5);
    return rnd_state;
  endfunction

  // decode only ever offers 00, 01 or 11
  function automatic logic [1:0] pick_ready();
    logic [31:0] r;
    r = next_random() % 32'd3;
    return (r == 32'd0) ? 2'b00 : ((r == 32'd1) ? 2'b01 : 2'b11);
  endfunction

  // any halfword inside the image
  function automatic logic [31:0] random_target();
    return (next_random() % 32'd256) * 32'd2;
  endfunction

  // halfword at a byte address, wrapping like the memory does
  function automatic logic [15:0] image_hw(input logic [31:0] addr);
    return image[addr[8:3]][{addr[2:1], 4'b0000} +: 16];
  endfunction

  task automatic put_hw(input int idx, input logic [15:0] val);
    image[idx[7:2]][{idx[1:0], 4'b0000} +: 16] = val;
  endtask

  // halfword stream, 16-bit and 32-bit encodings mixed at random
  task automatic fill_image();
    logic [31:0] r;
    int          hw;
    hw = 0;
    while (hw < 256) begin
      r = next_random();
      if (r[0]) begin
        put_hw(hw, {r[31:18], (r[2:1] == 2'b11) ? 2'b00 : r[2:1]});
        hw++;
      end else begin
        put_hw(hw, {r[31:18], 2'b11});
        // last one wraps onto halfword 0
        put_hw((hw + 1) % 256, r[17:2]);
        hw += 2;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks and model
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                          input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic compare_with_model(input ir_reg_t ir);
    logic [15:0] hw0;
    logic        comp;
    logic [31:0] last;
    logic        exp_err;
    if (skipping) begin
      return;
    end
    hw0     = image_hw(model_pc);
    comp    = (hw0[1:0] != 2'b11);
    // a 32-bit one may straddle into the next doubleword
    last    = comp ? model_pc : model_pc + 32'd2;
    exp_err = model_err_on && ((model_pc[8:3] == err_idx) || (last[8:3] == err_idx));
    check_eq(ir.pc, model_pc, "pc");
    check_eq(32'(ir.err), 32'(exp_err), "err");
    if (exp_err) begin
      // faulty fetch, nothing behind it is meaningful until the next redirect
      skipping = 1'b1;
      err_seen = 1'b1;
    end else begin
      check_eq(32'(ir.is_comp), 32'(comp), "is_comp");
      // upper half of a compressed one is don't care
      check_eq(comp ? {16'd0, ir.insn[15:0]} : ir.insn,
               comp ? {16'd0, hw0} : {image_hw(model_pc + 32'd2), hw0}, "insn");
      model_pc = model_pc + (comp ? 32'd2 : 32'd4);
    end
    xfer_count++;
  endtask

  // one clock, driven on the falling edge and sampled just at the rising edge
  // redir_mode 1 waits for an outstanding request, 2 redirects at once
  task automatic step_clock(input logic [1:0] ready, input int redir_mode,
                            input logic [31:0] target, output logic redir_done);
    logic [1:0]  xfr;
    logic [15:0] head_hw;
    @(negedge clk_i);
    redir_done    = (redir_mode == 2) || ((redir_mode == 1) && mem_req);
    redirect      = redir_done;
    redirect_addr = target;
    out_ready     = redir_done ? 2'b00 : ready;
    @(posedge clk_i);
    xfr     = out_valid & out_ready;
    head_hw = image_hw(model_pc);
    // instr1 sits 2 or 4 bytes behind instr0 in the model's stream
    if (xfr[1] && !skipping) begin
      check_eq(instr1.pc, model_pc + ((head_hw[1:0] != 2'b11) ? 32'd2 : 32'd4),
               "instr1 pc step");
    end
    if (xfr[0]) begin
      compare_with_model(instr0);
    end
    if (xfr[1]) begin
      compare_with_model(instr1);
    end
    // responder reads these on the next falling edge
    ack_delay = 2'(next_random() % 32'd4);
    if (redir_done) begin
      err_en       = err_arm;
      model_err_on = err_arm;
      model_pc     = target;
      skipping     = 1'b0;
    end
  endtask

  // n transfers, or until the injected fault reaches decode
  task automatic run_transfers(input int n, input logic random_ready,
                               input logic until_fault);
    int   start;
    int   cyc;
    logic done;
    start = xfer_count;
    cyc   = 0;
    while ((until_fault ? !err_seen : (xfer_count - start < n)) && cyc < WAIT_LIMIT) begin
      step_clock(random_ready ? pick_ready() : 2'b11, 0, 32'd0, done);
      cyc++;
    end
    if (until_fault ? !err_seen : (xfer_count - start < n)) begin
      errors++;
      $display("timeout: decode stream stalled after %0d transfers", xfer_count - start);
    end
  endtask

  task automatic redirect_to(input logic [31:0] target, input int mode);
    int   cyc;
    logic done;
    cyc  = 0;
    done = 1'b0;
    while (!done && cyc < WAIT_LIMIT) begin
      step_clock(pick_ready(), mode, target, done);
      cyc++;
    end
    if (!done) begin
      errors++;
      $display("timeout: no request went out to redirect against");
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s done, %0d transfers, %0d errors", num, name, xfer_count, errors);
  endtask

  // four-phase rule, req rises only with ack low and holds its address
  always @(negedge clk_i) begin
    if (rst_ni && mem_req && !req_prev) begin
      check_eq(32'(mem_ack), 32'd0, "ack at req rise");
    end
    if (rst_ni && mem_req && req_prev) begin
      check_eq(mem_addr, addr_prev, "req address hold");
    end
    req_prev  <= mem_req;
    addr_prev <= mem_addr;
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rnd_state     = 32'd88558;
    rst_ni        = 1'b0;
    redirect      = 1'b0;
    redirect_addr = '0;
    out_ready     = 2'b00;
    ack_delay     = 2'd0;
    err_en        = 1'b0;
    err_idx       = 6'd0;
    err_arm       = 1'b0;
    model_pc      = 32'd0;
    model_err_on  = 1'b0;
    skipping      = 1'b0;
    err_seen      = 1'b0;
    req_prev      = 1'b0;
    addr_prev     = '0;
    xfer_count    = 0;
    checks        = 0;
    errors        = 0;
    fill_image();
    repeat (8) begin
      @(negedge clk_i);
      check_eq(32'(mem_req), 32'd0, "req in reset");
      check_eq(32'(out_valid), 32'd0, "valid in reset");
    end
    rst_ni = 1'b1;
    // first instruction comes from pc 0
    run_transfers(1, 1'b0, 1'b0);
    report_test(1, "reset");
    run_transfers(200, 1'b0, 1'b0);
    report_test(2, "sequential");
    run_transfers(300, 1'b1, 1'b0);
    report_test(3, "backpressure");
    repeat (20) begin
      redirect_to(random_target(), 1);
      run_transfers(12, 1'b1, 1'b0);
    end
    report_test(4, "redirect");
    // start a few halfwords ahead of the faulty doubleword
    err_idx = 6'(32'd8 + next_random() % 32'd48);
    err_arm = 1'b1;
    redirect_to(32'(err_idx - 6'd1) * 32'd8 + (next_random() % 32'd4) * 32'd2, 2);
    run_transfers(0, 1'b1, 1'b1);
    err_arm = 1'b0;
    redirect_to(random_target(), 2);
    run_transfers(40, 1'b1, 1'b0);
    report_test(5, "fetch error");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+.
fetch_pkg.sv
fetch_fifo64.sv
prefetch_ctrl.sv
prefetch_top.sv
tb_mem_responder.sv
tb_prefetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f \
  --top-module tb_prefetch_top -o tb_prefetch_top

./obj_dir/tb_prefetch_top | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
